//--- act_pkg.sv
`default_nettype none

package act_pkg;

	// activation select, sigmoid after reset
	typedef enum logic
	{
		act_sigmoid = 1'b0, // table holds sigmoid - 0.5
		act_tanh    = 1'b1  // table holds tanh directly
	} act_type_e;

	// stream word, same for in_data and out_data
	localparam int word_w = 32;

	// significant input bits: 4 ext int + 16 calc + 4 ext frac
	localparam int in_w = 24;

	// fraction bits on both sides (10 calc + 4 extra)
	localparam int frac_w = 14;

	// one register per stage, sets out_vld latency
	localparam int pipe_depth = 3;

endpackage

`default_nettype wire

//--- lut_pkg.sv
`default_nettype none

package lut_pkg;

	localparam int lut_aw = 11; // 2048 entries per function
	localparam int lut_dw = 16; // Q15 magnitude
	localparam int lut_depth = 2 ** lut_aw;

	// segment level of |x|, seg_sat bypasses the table
	typedef enum logic [1:0]
	{
		seg_0,
		seg_1,
		seg_2,
		seg_sat
	} seg_e;

	localparam int seg_base_1 = 1024; // seg_0 gets 1024 points
	localparam int seg_base_2 = 1536; // seg_1 and seg_2 get 512 each

	// segment edges and saturation point, whole units of x
	localparam int sig_edge_1 = 2;
	localparam int sig_edge_2 = 4;
	localparam int sig_sat = 8;
	localparam int tanh_edge_1 = 1;
	localparam int tanh_edge_2 = 2;
	localparam int tanh_sat = 4;

	localparam int one_q15 = 32768; // 1.0 in Q15, needs 17 bits

endpackage

`default_nettype wire

//--- act_lut_rom.sv
`timescale 1ns/100ps
`default_nettype none

module act_lut_rom
(
	input wire clk,
	input wire act_pkg::act_type_e active_type, // bank select
	input wire lut_ren,
	input wire [lut_pkg::lut_aw-1:0] lut_raddr,
	output logic [lut_pkg::lut_dw-1:0] lut_dout
);

	// bank 0 sigmoid, bank 1 tanh
	logic [lut_pkg::lut_dw-1:0] mem [2*lut_pkg::lut_depth];

	// value at the left edge of step idx, rounded Q15
	function automatic logic [lut_pkg::lut_dw-1:0] lut_entry(input int bank, input int idx);
		real e1;
		real e2;
		real e3;
		real x;
		real y;
		real v;
		e1 = (bank == 0) ? real'(lut_pkg::sig_edge_1) : real'(lut_pkg::tanh_edge_1);
		e2 = (bank == 0) ? real'(lut_pkg::sig_edge_2) : real'(lut_pkg::tanh_edge_2);
		e3 = (bank == 0) ? real'(lut_pkg::sig_sat) : real'(lut_pkg::tanh_sat);
		if (idx < lut_pkg::seg_base_1)
			x = e1 * idx / lut_pkg::seg_base_1; // fine segment near zero
		else if (idx < lut_pkg::seg_base_2)
			x = e1 + (e2 - e1) * (idx - lut_pkg::seg_base_1)
				/ (lut_pkg::seg_base_2 - lut_pkg::seg_base_1);
		else
			x = e2 + (e3 - e2) * (idx - lut_pkg::seg_base_2)
				/ (lut_pkg::lut_depth - lut_pkg::seg_base_2);
		if (bank == 0)
			y = 1.0 / (1.0 + $exp(-x)) - 0.5; // offset removed, core adds it back
		else
			y = $tanh(x);
		v = $floor(y * lut_pkg::one_q15 + 0.5);
		// tanh tops out just under 1.0, keep it in 16 bits
		if (v > lut_pkg::one_q15 - 1)
			v = lut_pkg::one_q15 - 1;
		return lut_pkg::lut_dw'($rtoi(v));
	endfunction

	// contents computed at elaboration
	initial
	begin
		for (int b = 0; b < 2; b++)
		begin
			for (int i = 0; i < lut_pkg::lut_depth; i++)
				mem[b*lut_pkg::lut_depth+i] = lut_entry(b, i);
		end
	end

	// one-cycle registered read
	always_ff @(posedge clk)
	begin
		if (lut_ren)
			lut_dout <= mem[{active_type, lut_raddr}];
	end

endmodule

`default_nettype wire

//--- act_mode_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module act_mode_ctrl
(
	input wire clk,
	input wire rst_n,
	input wire mode_req,
	input wire act_pkg::act_type_e mode_type,
	output logic mode_ack,
	input wire busy, // some stage still holds a sample
	input wire in_vld,
	output act_pkg::act_type_e active_type
);

	// four-phase handshake, ack doubles as commit strobe
	typedef enum logic [1:0]
	{
		st_idle,
		st_wait_empty,
		st_acked
	} state_e;

	state_e state;
	logic drained; // pipe empty and nothing arriving this cycle

	assign drained = !busy && !in_vld;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			mode_ack <= 1'b0;
			active_type <= act_pkg::act_sigmoid;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (mode_req)
						state <= st_wait_empty; // ack never in the req edge
				end
				st_wait_empty:
				begin
					if (!mode_req)
						state <= st_idle; // host gave up, keep old type
					else if (drained)
					begin
						active_type <= mode_type; // samples after this use the new type
						mode_ack <= 1'b1;
						state <= st_acked;
					end
				end
				st_acked:
				begin
					if (!mode_req)
					begin
						mode_ack <= 1'b0; // phase 4
						state <= st_idle;
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- act_core.sv
`timescale 1ns/100ps
`default_nettype none

module act_core
(
	input wire clk,
	input wire rst_n,
	input wire act_pkg::act_type_e active_type,
	input wire in_vld,
	input wire [act_pkg::word_w-1:0] in_data,
	output logic lut_ren,
	output logic [lut_pkg::lut_aw-1:0] lut_raddr,
	input wire [lut_pkg::lut_dw-1:0] lut_dout,
	output logic out_vld,
	output logic [act_pkg::word_w-1:0] out_data,
	output logic busy
);

	logic [act_pkg::pipe_depth-1:0] vld_sr; // one valid bit per stage

	// stage 1 inputs
	logic sign_in; // input msb
	logic [act_pkg::in_w-1:0] abs_in; // |x|, fits since -2^23 maps to 2^23
	logic [act_pkg::in_w-1:0] thr_1;
	logic [act_pkg::in_w-1:0] thr_2;
	logic [act_pkg::in_w-1:0] thr_sat;
	lut_pkg::seg_e seg_in;

	// stage 1 regs
	logic [act_pkg::in_w-1:0] abs_q1;
	logic neg_q1;
	lut_pkg::seg_e seg_q1;

	// stage 2
	logic [act_pkg::in_w-1:0] mag; // |x| scaled to the tanh grid
	logic sat_q2;
	logic neg_q2;

	// stage 3
	logic signed [lut_pkg::lut_dw:0] lut_val; // signed Q15, 17 bits
	logic signed [lut_pkg::lut_dw:0] sat_val;
	logic signed [lut_pkg::lut_dw:0] half_val; // 0.5 for sigmoid, else 0
	logic signed [lut_pkg::lut_dw:0] act_v;
	logic signed [act_pkg::word_w-1:0] act_ext;

	// valid chain, only control state is reset
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			vld_sr <= '0;
		else
			vld_sr <= {vld_sr[act_pkg::pipe_depth-2:0], in_vld};
	end

	assign busy = |vld_sr;
	assign out_vld = vld_sr[act_pkg::pipe_depth-1];

	assign sign_in = in_data[act_pkg::in_w-1];
	// two's complement magnitude
	assign abs_in = (in_data[act_pkg::in_w-1:0] ^ {act_pkg::in_w{sign_in}})
		+ act_pkg::in_w'(sign_in);

	// segment edges in input format, per type
	always_comb
	begin
		if (active_type == act_pkg::act_sigmoid)
		begin
			thr_1 = act_pkg::in_w'(lut_pkg::sig_edge_1 << act_pkg::frac_w);
			thr_2 = act_pkg::in_w'(lut_pkg::sig_edge_2 << act_pkg::frac_w);
			thr_sat = act_pkg::in_w'(lut_pkg::sig_sat << act_pkg::frac_w);
		end
		else
		begin
			thr_1 = act_pkg::in_w'(lut_pkg::tanh_edge_1 << act_pkg::frac_w);
			thr_2 = act_pkg::in_w'(lut_pkg::tanh_edge_2 << act_pkg::frac_w);
			thr_sat = act_pkg::in_w'(lut_pkg::tanh_sat << act_pkg::frac_w);
		end
	end

	always_comb
	begin
		if (abs_in >= thr_sat)
			seg_in = lut_pkg::seg_sat;
		else if (abs_in >= thr_2)
			seg_in = lut_pkg::seg_2;
		else if (abs_in >= thr_1)
			seg_in = lut_pkg::seg_1;
		else
			seg_in = lut_pkg::seg_0;
	end

	// stage 1: payload, no reset
	always_ff @(posedge clk)
	begin
		if (in_vld)
		begin
			abs_q1 <= abs_in;
			neg_q1 <= sign_in;
			seg_q1 <= seg_in;
		end
	end

	// sigmoid edges are twice the tanh ones, so halve and share the slices
	assign mag = (active_type == act_pkg::act_sigmoid) ? (abs_q1 >> 1) : abs_q1;

	always_comb
	begin
		case (seg_q1)
			lut_pkg::seg_0: // 1024 steps over the first edge
				lut_raddr = lut_pkg::lut_aw'(mag[act_pkg::frac_w-1 -: 10]);
			lut_pkg::seg_1: // 512 steps, integer bit dropped
				lut_raddr = lut_pkg::lut_aw'(lut_pkg::seg_base_1)
					+ lut_pkg::lut_aw'(mag[act_pkg::frac_w-1 -: 9]);
			lut_pkg::seg_2: // 512 steps, coarser
				lut_raddr = lut_pkg::lut_aw'(lut_pkg::seg_base_2)
					+ lut_pkg::lut_aw'(mag[act_pkg::frac_w -: 9]);
			default:
				lut_raddr = '0; // no read anyway
		endcase
	end

	assign lut_ren = vld_sr[0] && (seg_q1 != lut_pkg::seg_sat); // saturated skips rom

	// stage 2 flags, aligned with lut_dout
	always_ff @(posedge clk)
	begin
		if (vld_sr[0])
		begin
			sat_q2 <= (seg_q1 == lut_pkg::seg_sat);
			neg_q2 <= neg_q1;
		end
	end

	// odd symmetry for both functions once the offset is out
	assign lut_val = neg_q2 ? -$signed({1'b0, lut_dout}) : $signed({1'b0, lut_dout});

	always_comb
	begin
		if (active_type == act_pkg::act_sigmoid)
		begin
			sat_val = (lut_pkg::lut_dw+1)'(lut_pkg::one_q15 / 2); // sigmoid - 0.5 tops at 0.5
			half_val = (lut_pkg::lut_dw+1)'(lut_pkg::one_q15 / 2);
		end
		else
		begin
			sat_val = (lut_pkg::lut_dw+1)'(lut_pkg::one_q15); // tanh tops at 1.0
			half_val = '0;
		end
		if (neg_q2)
			sat_val = -sat_val;
	end

	assign act_v = (sat_q2 ? sat_val : lut_val) + half_val; // range [-1.0, 1.0]
	assign act_ext = {{(act_pkg::word_w-lut_pkg::lut_dw-1){act_v[lut_pkg::lut_dw]}}, act_v};

	// stage 3: Q15 down to frac_w, arithmetic shift keeps the sign
	always_ff @(posedge clk)
	begin
		if (vld_sr[1])
			out_data <= act_ext >>> (lut_pkg::lut_dw - 1 - act_pkg::frac_w);
	end

endmodule

`default_nettype wire

//--- act_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

module act_unit_top
(
	input wire clk,
	input wire rst_n,
	input wire in_vld,
	input wire [act_pkg::word_w-1:0] in_data,
	output logic out_vld,
	output logic [act_pkg::word_w-1:0] out_data,
	input wire mode_req,
	input wire act_pkg::act_type_e mode_type,
	output logic mode_ack,
	output act_pkg::act_type_e active_type
);

	logic busy; // core -> mode ctrl
	logic lut_ren;
	logic [lut_pkg::lut_aw-1:0] lut_raddr;
	logic [lut_pkg::lut_dw-1:0] lut_dout;

	// type register and handshake
	act_mode_ctrl act_mode_ctrl_inst
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.mode_req    (mode_req),
		.mode_type   (mode_type),
		.mode_ack    (mode_ack),
		.busy        (busy),
		.in_vld      (in_vld),
		.active_type (active_type)
	);

	// 3-stage datapath
	act_core act_core_inst
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.active_type (active_type),
		.in_vld      (in_vld),
		.in_data     (in_data),
		.lut_ren     (lut_ren),
		.lut_raddr   (lut_raddr),
		.lut_dout    (lut_dout),
		.out_vld     (out_vld),
		.out_data    (out_data),
		.busy        (busy)
	);

	act_lut_rom act_lut_rom_inst
	(
		.clk         (clk),
		.active_type (active_type), // bank stays put while busy
		.lut_ren     (lut_ren),
		.lut_raddr   (lut_raddr),
		.lut_dout    (lut_dout)
	);

endmodule

`default_nettype wire

//--- act_checker.sv
`timescale 1ns/100ps
`default_nettype none

module act_checker
(
	input wire clk,
	input wire rst_n,
	input wire in_vld,
	input wire [act_pkg::word_w-1:0] in_data,
	input wire out_vld,
	input wire lut_ren,
	input wire mode_req,
	input wire mode_ack,
	input wire act_pkg::act_type_e active_type
);

	logic [act_pkg::in_w-1:0] mag; // |x| of the arriving sample
	logic [act_pkg::in_w-1:0] sat_thr;
	logic sat_in;

	assign mag = in_data[act_pkg::in_w-1] ? (act_pkg::in_w'(0) - in_data[act_pkg::in_w-1:0])
		: in_data[act_pkg::in_w-1:0];
	assign sat_thr = (active_type == act_pkg::act_sigmoid)
		? act_pkg::in_w'(lut_pkg::sig_sat << act_pkg::frac_w)
		: act_pkg::in_w'(lut_pkg::tanh_sat << act_pkg::frac_w);
	assign sat_in = (mag >= sat_thr);

	// fixed latency in both directions
	out_after_in: assert property (@(posedge clk) disable iff (!rst_n)
		in_vld |-> ##3 out_vld)
		else $error("out_vld missing 3 cycles after in_vld");
	no_spurious_out: assert property (@(posedge clk) disable iff (!rst_n)
		!in_vld |-> ##3 !out_vld)
		else $error("out_vld without a matching in_vld");

	// saturated samples bypass the rom
	sat_no_read: assert property (@(posedge clk) disable iff (!rst_n)
		(in_vld && sat_in) |=> !lut_ren)
		else $error("rom read for a saturated sample");

	// req seen in the edge that raised ack
	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mode_ack) |-> $past(mode_req))
		else $error("mode_ack rose without mode_req");

endmodule

// attached to the top so both the core and the handshake are visible
bind act_unit_top act_checker act_checker_inst
(
	.clk         (clk),
	.rst_n       (rst_n),
	.in_vld      (in_vld),
	.in_data     (in_data),
	.out_vld     (out_vld),
	.lut_ren     (lut_ren),
	.mode_req    (mode_req),
	.mode_ack    (mode_ack),
	.active_type (active_type)
);

`default_nettype wire

//--- act_tb.sv
`timescale 1ns/100ps
`default_nettype none

module act_tb;

	localparam int ack_timeout = 20; // cycles
	localparam int drain_timeout = 20;

	logic clk;
	logic rst_n;
	logic in_vld;
	logic [act_pkg::word_w-1:0] in_data;
	logic mode_req;
	act_pkg::act_type_e mode_type;
	logic out_vld;
	logic [act_pkg::word_w-1:0] out_data;
	logic mode_ack;
	act_pkg::act_type_e active_type;

	logic [31:0] exp_q[$]; // scoreboard in issue order
	string name_q[$];
	act_pkg::act_type_e cur_type; // type the tb believes is active
	act_pkg::act_type_e new_type;
	bit req_pending;

	act_unit_top act_unit_top_inst
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.in_vld      (in_vld),
		.in_data     (in_data),
		.out_vld     (out_vld),
		.out_data    (out_data),
		.mode_req    (mode_req),
		.mode_type   (mode_type),
		.mode_ack    (mode_ack),
		.active_type (active_type)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expv, input logic [31:0] actv);
		if (expv !== actv)
		begin
			$display("** Error %s: expected %h, actual %h", name, expv, actv);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// check any due output and drive on the next falling edge
	task automatic step(input logic vld, input logic [31:0] data);
		@(negedge clk);
		if (out_vld)
		begin
			if (exp_q.size() == 0)
				fail_run("output valid while no sample was in flight");
			check_value(name_q.pop_front(), exp_q.pop_front(), out_data);
		end
		in_vld = vld;
		in_data = data;
	endtask

	task automatic send(input string name, input logic [31:0] data, input logic [31:0] expv);
		int gap;
		gap = req_pending ? 0 : int'($urandom % 3); // back to back while a request waits
		repeat (gap) step(1'b0, '0);
		exp_q.push_back(expv);
		name_q.push_back(name);
		step(1'b1, data);
	endtask

	// saturated result from sign and current type
	function automatic logic [31:0] sat_expect(input logic [31:0] data);
		if (cur_type == act_pkg::act_sigmoid)
			return data[act_pkg::in_w-1] ? 32'd0 : 32'd16384;
		return data[act_pkg::in_w-1] ? -32'sd16384 : 32'd16384;
	endfunction

	task automatic wait_ack(input logic level, input string name);
		for (int i = 0; i < ack_timeout; i++)
		begin
			step(1'b0, '0);
			if (mode_ack === level)
				return;
		end
		fail_run({"mode_ack did not reach the expected level in time at ", name});
	endtask

	task automatic finish_handshake(input string name);
		wait_ack(1'b1, name);
		check_value({name, " drained"}, 32'd0, 32'(exp_q.size())); // nothing left in flight
		check_value({name, " type"}, 32'(new_type), 32'(active_type));
		cur_type = new_type;
		mode_req = 1'b0; // phase 3
		req_pending = 1'b0;
		wait_ack(1'b0, name);
	endtask

	initial
	begin
		int fd;
		int r;
		int t;
		string kind;
		string name;
		string rest;
		logic [31:0] din;
		logic [31:0] dexp;

		void'($urandom(32'h780f_4ed2));
		rst_n = 1'b0;
		in_vld = 1'b0;
		in_data = '0;
		mode_req = 1'b0;
		mode_type = act_pkg::act_sigmoid;
		cur_type = act_pkg::act_sigmoid;
		new_type = act_pkg::act_sigmoid;
		req_pending = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		check_value("reset out_vld", 32'd0, 32'(out_vld));
		check_value("reset mode_ack", 32'd0, 32'(mode_ack));
		check_value("reset type", 32'(act_pkg::act_sigmoid), 32'(active_type));

		fd = $fopen("act_patterns.txt", "r");
		if (fd == 0)
			fail_run("cannot open act_patterns.txt");
		while (!$feof(fd))
		begin
			r = $fscanf(fd, "%s", kind);
			if (r != 1)
				break;
			if (kind.substr(0, 0) == "#")
				r = $fgets(rest, fd); // comment line
			else if (kind == "S")
			begin
				r = $fscanf(fd, "%s %h %h", name, din, dexp);
				send(name, din, dexp);
			end
			else if (kind == "T")
			begin
				r = $fscanf(fd, "%s %h", name, din);
				send(name, din, sat_expect(din));
			end
			else if (kind == "M")
			begin
				r = $fscanf(fd, "%s %d", name, t);
				new_type = act_pkg::act_type_e'(t);
				mode_type = new_type;
				mode_req = 1'b1;
				finish_handshake(name);
			end
			else if (kind == "R")
			begin
				r = $fscanf(fd, "%s %d", name, t); // request rides along with the next burst
				new_type = act_pkg::act_type_e'(t);
				mode_type = new_type;
				mode_req = 1'b1;
				req_pending = 1'b1;
			end
			else if (kind == "W")
			begin
				r = $fscanf(fd, "%s", name);
				finish_handshake(name);
			end
			else
				fail_run({"unknown record kind in pattern file: ", kind});
		end
		$fclose(fd);

		for (int i = 0; i < drain_timeout && exp_q.size() != 0; i++)
			step(1'b0, '0);
		if (exp_q.size() != 0)
			fail_run("samples still missing at the end of the run");
		else
		begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- act_patterns.txt
# kind name fields: S name in_hex exp_hex | T name in_hex (saturated, tb computes)
# M name type (blocking handshake) | R name type (request during burst) | W name; type 0 sigmoid 1 tanh
S sig_zero 00000000 00002000
S sig_p05 00002000 000027D6
S sig_n05 FFFFE000 00001829
S sig_p1 00004000 00002EC9
S sig_n1 FFFFC000 00001136
S sig_p1_mid 0000400A 00002EC9
S sig_p2 00008000 0000385F
S sig_n2 FFFF8000 000007A1
S sig_p4 00010000 00003ED9
S sig_n4 FFFF0000 00000126
T sig_sat_p8 00020000
T sig_sat_n8 FFFE0000
T sig_sat_n10 FFFD8000
T sig_sat_p20 00050000
S sig_rep_p1 00004000 00002EC9
S sig_rep_n05 FFFFE000 00001829
M to_tanh 1
S tanh_zero 00000000 00000000
S tanh_p05 00002000 00001D93
S tanh_n05 FFFFE000 FFFFE26C
S tanh_p1 00004000 000030BE
S tanh_n1 FFFFC000 FFFFCF42
S tanh_p2 00008000 00003DB2
S tanh_n2 FFFF8000 FFFFC24D
T tanh_sat_p4 00010000
T tanh_sat_n4 FFFF0000
T tanh_sat_n6 FFFE8000
S tanh_p1_mid 00004005 000030BE
R burst_to_sig 0
S burst_b1 00002000 00001D93
S burst_b2 FFFFC000 FFFFCF42
S burst_b3 00008000 00003DB2
S burst_b4 00000000 00000000
S burst_b5 FFFFE000 FFFFE26C
T burst_b6 00010000
S burst_b7 FFFF8000 FFFFC24D
W burst_to_sig_done
S sig_after_p1 00004000 00002EC9
S sig_after_n2 FFFF8000 000007A1
T sig_after_sat FFFE0000
S sig_after_p4 00010000 00003ED9
M back_to_tanh 1
S tanh_after_p1 00004000 000030BE
T tanh_after_sat 00020000

//--- files.f
act_pkg.sv
lut_pkg.sv
act_lut_rom.sv
act_mode_ctrl.sv
act_core.sv
act_unit_top.sv
act_checker.sv
act_tb.sv

//--- Makefile
TOP = act_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir
